// File: design/l2_cache.sv
//**************************************************************************
// Four-way write-back L2 cache for one requester
// Word port toward the requester, line port toward the next level
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module l2_cache (
	input wire clk,
	input wire reset,
	input wire req,
	input wire we,
	input wire [l2_cache_pkg::addr_width-1:0] addr,
	input wire [l2_cache_pkg::word_width-1:0] wdata,
	output logic done,
	output logic hit,
	output logic [l2_cache_pkg::word_width-1:0] rdata,
	output logic mem_read,
	output logic mem_write,
	output logic [l2_cache_pkg::addr_width-1:0] mem_addr,
	output logic [l2_cache_pkg::line_width-1:0] mem_wdata,
	input wire [l2_cache_pkg::line_width-1:0] mem_rdata,
	input wire mem_ready
);

	logic lookup_hit;
	logic [l2_cache_pkg::way_width-1:0] hit_way;
	logic [l2_cache_pkg::way_width-1:0] victim_way;
	logic victim_dirty;
	logic [l2_cache_pkg::tag_width-1:0] victim_tag;
	logic touch;
	logic fill;
	logic set_dirty;
	logic clear_dirty;
	logic word_we;
	logic [l2_cache_pkg::way_width-1:0] sel_way;

	l2_cache_ctrl u_ctrl (
		.clk, .reset, .req, .we, .addr,
		.lookup_hit, .hit_way, .victim_way, .victim_dirty, .victim_tag,
		.mem_ready, .done, .hit,
		.touch, .fill, .set_dirty, .clear_dirty, .word_we, .sel_way,
		.mem_read, .mem_write, .mem_addr
	);

	l2_tag_store u_tag_store (
		.clk, .reset, .addr,
		.touch, .fill, .set_dirty, .clear_dirty, .sel_way,
		.lookup_hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
	);

	// Selected line goes straight out as write-back data
	l2_data_store u_data_store (
		.clk, .reset, .addr, .sel_way, .word_we, .wdata, .fill, .mem_rdata,
		.rdata, .line_out (mem_wdata)
	);

endmodule

`default_nettype wire

// File: design/l2_cache_ctrl.sv
//**************************************************************************
// L2 cache control FSM, one request at a time
// Sequences lookup, dirty victim write-back, line allocation and done
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module l2_cache_ctrl (
	input wire clk,
	input wire reset,
	input wire req,
	input wire we,
	input wire [l2_cache_pkg::addr_width-1:0] addr,
	input wire lookup_hit,
	input wire [l2_cache_pkg::way_width-1:0] hit_way,
	input wire [l2_cache_pkg::way_width-1:0] victim_way,
	input wire victim_dirty,
	input wire [l2_cache_pkg::tag_width-1:0] victim_tag,
	input wire mem_ready,
	output logic done,
	output logic hit,
	output logic touch,
	output logic fill,
	output logic set_dirty,
	output logic clear_dirty,
	output logic word_we,
	output logic [l2_cache_pkg::way_width-1:0] sel_way,
	output logic mem_read,
	output logic mem_write,
	output logic [l2_cache_pkg::addr_width-1:0] mem_addr
);

	l2_cache_pkg::ctrl_state_t state, next_state;

	logic missed;  // Set once the current request has missed
	logic [l2_cache_pkg::index_width-1:0] index;
	logic [l2_cache_pkg::tag_width-1:0] req_tag;
	logic [l2_cache_pkg::tag_width-1:0] line_tag;

	assign index = addr[l2_cache_pkg::byte_offset_width + l2_cache_pkg::word_offset_width +:
		l2_cache_pkg::index_width];
	assign req_tag = addr[l2_cache_pkg::addr_width-1 -: l2_cache_pkg::tag_width];

	// Victim line address while writing back, else the requested line
	assign line_tag = (state == l2_cache_pkg::write_back) ? victim_tag : req_tag;
	assign mem_addr = {line_tag, index,
		{(l2_cache_pkg::word_offset_width + l2_cache_pkg::byte_offset_width){1'b0}}};

	// Hit way in compare, victim way on the miss path
	assign sel_way = (state == l2_cache_pkg::compare) ? hit_way : victim_way;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state <= l2_cache_pkg::idle;
			missed <= 1'b0;
		end else begin
			state <= next_state;
			if (state == l2_cache_pkg::idle && req)
				missed <= 1'b0;  // Fresh request
			else if (state == l2_cache_pkg::compare && !lookup_hit)
				missed <= 1'b1;
		end
	end

	always_comb begin
		next_state = state;
		done = 1'b0;
		hit = 1'b0;
		touch = 1'b0;
		fill = 1'b0;
		set_dirty = 1'b0;
		clear_dirty = 1'b0;
		word_we = 1'b0;
		mem_read = 1'b0;
		mem_write = 1'b0;
		case (state)
			l2_cache_pkg::idle: begin
				if (req)
					next_state = l2_cache_pkg::compare;
			end
			l2_cache_pkg::compare: begin
				if (lookup_hit) begin
					done = 1'b1;
					hit = !missed;     // Low after a refill
					touch = 1'b1;
					word_we = we;
					set_dirty = we;
					next_state = l2_cache_pkg::idle;
				end else if (victim_dirty) begin
					next_state = l2_cache_pkg::write_back;
				end else begin
					next_state = l2_cache_pkg::allocate;
				end
			end
			l2_cache_pkg::write_back: begin
				mem_write = 1'b1;  // Held until the next level takes the line
				if (mem_ready) begin
					clear_dirty = 1'b1;
					next_state = l2_cache_pkg::allocate;
				end
			end
			l2_cache_pkg::allocate: begin
				mem_read = 1'b1;
				if (mem_ready) begin
					fill = 1'b1;  // Line lands in the victim way
					next_state = l2_cache_pkg::compare;
				end
			end
			default: next_state = l2_cache_pkg::idle;
		endcase
	end

	// Next-level port carries one command at a time
	assert property (@(posedge clk) disable iff (reset) !(mem_read && mem_write))
		else $error("ctrl: mem_read and mem_write both high");

	// Requester holds req through the whole request
	assert property (@(posedge clk) disable iff (reset) done |-> req)
		else $error("ctrl: done without req");

endmodule

`default_nettype wire

// File: design/l2_cache_pkg.sv
//**************************************************************************
// Geometry and controller state encoding for the four-way L2 cache
// Referenced from the RTL through scoped names
//**************************************************************************
`default_nettype none

package l2_cache_pkg;

	// Requester side
	localparam int addr_width = 32;
	localparam int word_width = 32;

	// Line geometry
	localparam int words_per_line = 4;
	localparam int line_width = words_per_line * word_width;   // 128 bits to the next level

	// Set associativity
	localparam int num_sets = 16;
	localparam int num_ways = 4;

	// Address split, low to high
	localparam int byte_offset_width = 2;                      // Ignored by the design
	localparam int word_offset_width = $clog2(words_per_line); // Bits 3:2
	localparam int index_width = $clog2(num_sets);             // Bits 7:4
	localparam int tag_width = addr_width - index_width - word_offset_width - byte_offset_width;

	// Way number and LRU rank
	localparam int way_width = $clog2(num_ways);
	localparam int lru_width = $clog2(num_ways);  // Rank 0 is least recent

	// Controller states
	typedef enum logic [1:0] {
		idle,
		compare,
		write_back,
		allocate
	} ctrl_state_t;

endpackage

`default_nettype wire

// File: design/l2_data_store.sv
//**************************************************************************
// Line data array of the L2 cache
// Word read and whole-line read of the selected way, word write or line fill
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module l2_data_store (
	input wire clk,
	input wire reset,
	input wire [l2_cache_pkg::addr_width-1:0] addr,
	input wire [l2_cache_pkg::way_width-1:0] sel_way,
	input wire word_we,
	input wire [l2_cache_pkg::word_width-1:0] wdata,
	input wire fill,
	input wire [l2_cache_pkg::line_width-1:0] mem_rdata,
	output logic [l2_cache_pkg::word_width-1:0] rdata,
	output logic [l2_cache_pkg::line_width-1:0] line_out
);

	logic [l2_cache_pkg::line_width-1:0] line_mem [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];

	logic [l2_cache_pkg::index_width-1:0] index;
	logic [l2_cache_pkg::word_offset_width-1:0] offset;

	assign index = addr[l2_cache_pkg::byte_offset_width + l2_cache_pkg::word_offset_width +:
		l2_cache_pkg::index_width];
	assign offset = addr[l2_cache_pkg::byte_offset_width +: l2_cache_pkg::word_offset_width];

	// Whole line feeds the write-back path
	assign line_out = line_mem[index][sel_way];
	assign rdata = line_out[offset * l2_cache_pkg::word_width +: l2_cache_pkg::word_width];

	always_ff @(posedge clk) begin
		if (fill)
			line_mem[index][sel_way] <= mem_rdata;  // Line from the next level
		else if (word_we)
			line_mem[index][sel_way][offset * l2_cache_pkg::word_width +:
				l2_cache_pkg::word_width] <= wdata;
	end

	// A fill takes a fully known line from the next level
	assert property (@(posedge clk) disable iff (reset) fill |-> !$isunknown(mem_rdata))
		else $error("data store: fill with unknown line data");

endmodule

`default_nettype wire

// File: design/l2_tag_store.sv
//**************************************************************************
// Tag, valid, dirty and LRU arrays of the L2 cache
// Lookup and victim choice are combinational, updates land on the next edge
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module l2_tag_store (
	input wire clk,
	input wire reset,
	input wire [l2_cache_pkg::addr_width-1:0] addr,
	input wire touch,
	input wire fill,
	input wire set_dirty,
	input wire clear_dirty,
	input wire [l2_cache_pkg::way_width-1:0] sel_way,
	output logic lookup_hit,
	output logic [l2_cache_pkg::way_width-1:0] hit_way,
	output logic [l2_cache_pkg::way_width-1:0] victim_way,
	output logic victim_dirty,
	output logic [l2_cache_pkg::tag_width-1:0] victim_tag
);

	logic [l2_cache_pkg::tag_width-1:0] tag_mem [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
	logic [l2_cache_pkg::lru_width-1:0] lru_mem [l2_cache_pkg::num_sets][l2_cache_pkg::num_ways];
	logic [l2_cache_pkg::num_ways-1:0] valid_mem [l2_cache_pkg::num_sets];
	logic [l2_cache_pkg::num_ways-1:0] dirty_mem [l2_cache_pkg::num_sets];

	logic [l2_cache_pkg::index_width-1:0] index;
	logic [l2_cache_pkg::tag_width-1:0] tag;
	logic [l2_cache_pkg::num_ways-1:0] match;
	logic found_invalid;

	assign index = addr[l2_cache_pkg::byte_offset_width + l2_cache_pkg::word_offset_width +:
		l2_cache_pkg::index_width];
	assign tag = addr[l2_cache_pkg::addr_width-1 -: l2_cache_pkg::tag_width];

	// Tag compare across the set
	always_comb begin
		hit_way = '0;
		for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
			match[w] = valid_mem[index][w] && (tag_mem[index][w] == tag);
			if (match[w])
				hit_way = l2_cache_pkg::way_width'(w);
		end
	end

	assign lookup_hit = |match;

	// Lowest invalid way first, else the rank 0 way
	always_comb begin
		victim_way = '0;
		found_invalid = 1'b0;
		for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
			if (!valid_mem[index][w] && !found_invalid) begin
				victim_way = l2_cache_pkg::way_width'(w);
				found_invalid = 1'b1;
			end
		end
		if (!found_invalid) begin
			for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
				if (lru_mem[index][w] == '0)
					victim_way = l2_cache_pkg::way_width'(w);
			end
		end
	end

	assign victim_dirty = valid_mem[index][victim_way] && dirty_mem[index][victim_way];
	assign victim_tag = tag_mem[index][victim_way];

	// Tag of the filled way
	always_ff @(posedge clk) begin
		if (fill)
			tag_mem[index][sel_way] <= tag;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int s = 0; s < l2_cache_pkg::num_sets; s++) begin
				valid_mem[s] <= '0;
				dirty_mem[s] <= '0;
				for (int w = 0; w < l2_cache_pkg::num_ways; w++)
					lru_mem[s][w] <= l2_cache_pkg::lru_width'(w); // Rank equals way number
			end
		end else begin
			// Touched way takes rank 3 and higher ranks slide down
			if (touch || fill) begin
				for (int w = 0; w < l2_cache_pkg::num_ways; w++) begin
					if (l2_cache_pkg::way_width'(w) == sel_way)
						lru_mem[index][w] <= '1;
					else if (lru_mem[index][w] > lru_mem[index][sel_way])
						lru_mem[index][w] <= lru_mem[index][w] - 1'b1;
				end
			end
			if (set_dirty)
				dirty_mem[index][sel_way] <= 1'b1;
			if (clear_dirty)
				dirty_mem[index][sel_way] <= 1'b0;
			if (fill) begin
				valid_mem[index][sel_way] <= 1'b1;
				dirty_mem[index][sel_way] <= 1'b0;  // New line arrives clean
			end
		end
	end

	// A set never holds the same tag twice
	assert property (@(posedge clk) disable iff (reset) $onehot0(match))
		else $error("tag store: more than one way matches");

endmodule

`default_nettype wire

// File: l2_cache.f
design/l2_cache_pkg.sv
design/l2_tag_store.sv
design/l2_data_store.sv
design/l2_cache_ctrl.sv
design/l2_cache.sv
test/l2_cache_tb.sv

// File: test/l2_cache_tb.sv
//**************************************************************************
// Testbench for the four-way L2 cache with a next-level memory model
// Predicts hit, write-back and read data per request and checks them at done
//**************************************************************************
`timescale 1ns/10ps
`default_nettype none

module l2_cache_tb;

	localparam int clk_period = 8;
	localparam int random_requests = 300;
	localparam int num_requests = random_requests + 12;
	localparam int miss_cycles = 24;  // Dirty victim and two slow transfers, with margin

	logic clk, reset, req, we, done, hit;
	logic mem_read, mem_write, mem_ready;
	logic [l2_cache_pkg::addr_width-1:0] addr, mem_addr;
	logic [l2_cache_pkg::word_width-1:0] wdata, rdata;
	logic [l2_cache_pkg::line_width-1:0] mem_wdata, mem_rdata;

	logic [31:0] backing [int unsigned];  // Next level, by word address
	logic [31:0] shadow [int unsigned];   // Latest value of every word

	// Reference tags and LRU ranks
	logic [23:0] ref_tag [16][4];
	bit ref_valid [16][4];
	bit ref_dirty [16][4];
	int ref_lru [16][4];

	string cur_test;
	logic exp_hit, exp_wb, exp_rd;
	logic [31:0] exp_rdata, exp_wb_addr, exp_rd_addr;
	logic [127:0] exp_wb_line;
	int wait_left;
	int errors;

	l2_cache dut (
		.clk, .reset, .req, .we, .addr, .wdata, .done, .hit, .rdata,
		.mem_read, .mem_write, .mem_addr, .mem_wdata, .mem_rdata, .mem_ready
	);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Words never written carry a pattern of their whole address
	function automatic logic [31:0] pattern_word(input logic [31:0] wa);
		return wa * 32'h9e37_79b1 + 32'h0bad_f00d;
	endfunction

	function automatic logic [31:0] expected_word(input logic [31:0] wa);
		return shadow.exists(wa) ? shadow[wa] : pattern_word(wa);
	endfunction

	function automatic logic [31:0] backing_word(input logic [31:0] wa);
		return backing.exists(wa) ? backing[wa] : pattern_word(wa);
	endfunction

	task automatic report_mismatch(input string what, input logic [127:0] expv,
		input logic [127:0] actv);
		errors++;
		$display("Fail %s: %s expected %0h, actual %0h", cur_test, what, expv, actv);
	endtask

	// Tag lookup, victim choice and true-LRU update for one request
	task automatic predict(input logic [31:0] a, input logic wr, input logic [31:0] wd);
		int s;
		int w;
		int old_rank;
		s = a[7:4];
		w = -1;
		exp_wb = 1'b0;
		exp_rd = 1'b0;
		for (int v = 0; v < 4; v++)
			if (ref_valid[s][v] && ref_tag[s][v] == a[31:8])
				w = v;
		exp_hit = (w >= 0);
		if (w < 0) begin
			for (int v = 3; v >= 0; v--)  // Lowest invalid way wins
				if (!ref_valid[s][v])
					w = v;
			if (w < 0)
				for (int v = 0; v < 4; v++)
					if (ref_lru[s][v] == 0)
						w = v;
			exp_wb = ref_valid[s][w] && ref_dirty[s][w];
			exp_wb_addr = {ref_tag[s][w], a[7:4], 4'h0};
			for (int i = 0; i < 4; i++)
				exp_wb_line[32*i +: 32] = expected_word(exp_wb_addr[31:2] + i);
			exp_rd = 1'b1;
			exp_rd_addr = {a[31:4], 4'h0};
			ref_tag[s][w] = a[31:8];
			ref_valid[s][w] = 1'b1;
			ref_dirty[s][w] = 1'b0;
		end
		old_rank = ref_lru[s][w];
		for (int v = 0; v < 4; v++)
			if (v == w)
				ref_lru[s][v] = 3;
			else if (ref_lru[s][v] > old_rank)
				ref_lru[s][v]--;
		if (wr) begin
			ref_dirty[s][w] = 1'b1;
			shadow[a[31:2]] = wd;
		end
		exp_rdata = expected_word(a[31:2]);
	endtask

	// Next level answers each transfer after 1 to 4 cycles
	always @(negedge clk) begin
		if (mem_ready) begin
			mem_ready = 1'b0;
		end else if (mem_read || mem_write) begin
			if (wait_left == 0)
				wait_left = $urandom_range(4, 1);
			wait_left--;
			if (wait_left == 0) begin
				if (mem_write) begin
					if (!exp_wb) begin
						errors++;
						$display("Error in %s: write-back of a line that is not dirty", cur_test);
					end
					if (mem_addr !== exp_wb_addr)
						report_mismatch("write-back address", exp_wb_addr, mem_addr);
					if (mem_wdata !== exp_wb_line)
						report_mismatch("write-back line", exp_wb_line, mem_wdata);
					exp_wb = 1'b0;
					for (int i = 0; i < 4; i++)
						backing[mem_addr[31:2] + i] = mem_wdata[32*i +: 32];
				end else begin
					if (!exp_rd || exp_wb) begin
						errors++;
						$display("Error in %s: line read without a miss or before write-back",
							cur_test);
					end
					if (mem_addr !== exp_rd_addr)
						report_mismatch("fill address", exp_rd_addr, mem_addr);
					exp_rd = 1'b0;
					for (int i = 0; i < 4; i++)
						mem_rdata[32*i +: 32] = backing_word(mem_addr[31:2] + i);
				end
				mem_ready = 1'b1;
			end
		end
	end

	// Compare against the prediction at every done
	always @(posedge clk) begin
		if (!reset && mem_read && mem_write) begin
			errors++;
			$display("Error in %s: mem_read and mem_write high together", cur_test);
		end
		if (!reset && done) begin
			if (hit !== exp_hit)
				report_mismatch("hit", exp_hit, hit);
			if (!we && rdata !== exp_rdata)
				report_mismatch("read data", exp_rdata, rdata);
			if (exp_wb || exp_rd) begin
				errors++;
				$display("Error in %s: done before the expected next-level transfers", cur_test);
			end
		end
	end

	task automatic do_request(input string name, input logic wr, input logic [31:0] a,
		input logic [31:0] wd);
		@(negedge clk);
		cur_test = name;
		predict(a, wr, wd);
		req = 1'b1;
		we = wr;
		addr = a;
		wdata = wd;
		do
			@(posedge clk);
		while (done !== 1'b1);
		@(negedge clk);
		req = 1'b0;  // One idle cycle between requests
	endtask

	initial begin
		logic [31:0] a;
		void'($urandom(32'hed64675a));
		errors = 0;
		wait_left = 0;
		cur_test = "reset";
		reset = 1'b1;
		req = 1'b0;
		we = 1'b0;
		addr = '0;
		wdata = '0;
		mem_ready = 1'b0;
		mem_rdata = '0;
		for (int s = 0; s < 16; s++)
			for (int w = 0; w < 4; w++) begin
				ref_valid[s][w] = 1'b0;
				ref_dirty[s][w] = 1'b0;
				ref_lru[s][w] = w;
			end
		repeat (8) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		if (done !== 1'b0 || mem_read !== 1'b0 || mem_write !== 1'b0) begin
			errors++;
			$display("Error in reset: done, mem_read or mem_write not low after reset");
		end

		do_request("first_read", 1'b0, 32'h0000_1040, '0);
		do_request("same_line_read", 1'b0, 32'h0000_1048, '0);
		do_request("write_hit", 1'b1, 32'h0000_1044, 32'hcafe_0001);
		for (int i = 0; i < 4; i++)
			do_request("line_readback", 1'b0, 32'h0000_1040 + 4 * i, '0);
		// Dirty line 0x1040 sits at rank 0 when the fifth tag of set 4 arrives
		for (int t = 1; t <= 4; t++)
			do_request("dirty_evict", 1'b0, 32'h0000_1040 + 32'h1000 * t, '0);
		do_request("clean_evict", 1'b0, 32'h0000_6040, '0);  // Victim 0x2040 is clean

		// Eight tags compete for every set
		for (int n = 0; n < random_requests; n++) begin
			a = $urandom_range(511, 0) << 2;
			do_request("random", $urandom_range(1, 0), a, $urandom);
		end

		$display("Requests %0d, errors %0d", num_requests, errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		#((10 + num_requests * miss_cycles) * clk_period);
		$display("Error: timeout, no done for request in %s", cur_test);
		$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
